//--- fixed_softmax.f
+incdir+logic
logic/softmax_pkg.sv
logic/softmax_block_if.sv
logic/exp_stage.sv
logic/exp_fifo.sv
logic/vector_sum.sv
logic/norm_divide.sv
logic/fixed_softmax.sv
tb/tb_fixed_softmax.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f fixed_softmax.f \
  --top-module tb_fixed_softmax -o sim_fixed_softmax

out=$(./obj_dir/sim_fixed_softmax) || true
echo "$out"
echo "$out" | grep -q "TEST PASSED"

//--- tb/tb_fixed_softmax.sv
`timescale 1ns/1ps
`default_nettype none
`include "softmax_macros.svh"

module tb_fixed_softmax;
  import softmax_pkg::*;

  localparam int FULL_RATE_VECS = 40;
  localparam int BP_VECS = 16;
  localparam int MAX_CYCLES = FULL_RATE_VECS * `SM_DEPTH * 8 + 200;
  localparam int MAX_CODE = (1 << (`SM_IN_W - 1)) - 1; // +7.9375
  localparam int MIN_CODE = 1 << (`SM_IN_W - 1); // -8.0
  localparam int KIND_RANDOM = 0;
  localparam int KIND_EQUAL = 1;
  localparam int KIND_MAX = 2;
  localparam int KIND_MIN = 3;
  localparam int KIND_ONE_MAX = 4;

  logic clk;
  logic rst;
  in_block_t in_data;
  logic in_valid;
  logic in_ready;
  out_block_t out_data;
  logic out_valid;
  logic out_ready;

  int seed;
  int gap_max;
  logic ready_random;
  int mismatch_count = 0;
  int other_count = 0;
  int blocks_sent = 0;
  int blocks_seen = 0;
  int cycle_count = 0;
  logic prev_stall;
  out_block_t prev_data;
  out_block_t want;
  out_block_t expected [$];
  in_block_t vec_blocks [`SM_DEPTH];

  fixed_softmax u_fixed_softmax (
    .clk (clk),
    .rst (rst),
    .in_data (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reference exponential, Q4.4 in, Q4.8 out with clamp
  function automatic exp_elem_t exp_ref(input in_elem_t code);
    real x;
    int r;
    x = real'($signed(code)) / 16.0;
    r = $rtoi($exp(x) * 256.0 + 0.5);
    if (r < 1) r = 1;
    if (r > 4095) r = 4095;
    return exp_elem_t'(r);
  endfunction

  task automatic check_block(input string name, input out_block_t actual,
                             input out_block_t exp_val);
    if (actual !== exp_val) begin
      mismatch_count++;
      $display("MISMATCH %s: got %h expected %h", name, actual, exp_val);
    end
  endtask

  task automatic check_idle();
    if (out_valid !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH out_valid: got %h expected %h", out_valid, 1'b0);
    end
    if (in_ready !== 1'b1) begin
      mismatch_count++;
      $display("MISMATCH in_ready: got %h expected %h", in_ready, 1'b1);
    end
  endtask

  // fills vec_blocks and queues the expected output blocks
  task automatic build_vector(input int kind);
    in_elem_t elems [`SM_VEC_LEN];
    exp_elem_t e [`SM_VEC_LEN];
    in_elem_t fill;
    out_block_t exp_blk;
    int total;
    int q;
    int r;
    int idx;
    fill = in_elem_t'($random(seed));
    total = 0;
    for (int i = 0; i < `SM_VEC_LEN; i++) begin
      case (kind)
        KIND_RANDOM: elems[i] = in_elem_t'($random(seed));
        KIND_EQUAL: elems[i] = fill;
        KIND_MAX: elems[i] = in_elem_t'(MAX_CODE);
        KIND_MIN: elems[i] = in_elem_t'(MIN_CODE);
        default: elems[i] = (i == 0) ? in_elem_t'(MAX_CODE) : in_elem_t'(MIN_CODE);
      endcase
      e[i] = exp_ref(elems[i]);
      total += int'(e[i]);
    end
    for (int b = 0; b < `SM_DEPTH; b++) begin
      for (int l = 0; l < `SM_LANES; l++) begin
        idx = b * `SM_LANES + l;
        vec_blocks[b][l] = elems[idx];
        q = ((int'(e[idx]) << `SM_EXP_FRAC) / total) & ((1 << `SM_EXP_W) - 1);
        r = (q + (1 << (`SM_EXP_FRAC - `SM_OUT_FRAC - 1))) >> (`SM_EXP_FRAC - `SM_OUT_FRAC);
        if (r > MAX_CODE) r = MAX_CODE; // output saturation
        exp_blk[l] = out_elem_t'(r);
      end
      expected.push_back(exp_blk);
    end
  endtask

  // transfer happens on the posedge after a negedge with in_ready high
  task automatic send_block(input in_block_t blk);
    int gap;
    if (gap_max > 0) begin
      gap = ($random(seed) & 32'h7fff_ffff) % (gap_max + 1);
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b1;
    in_data <= blk;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    blocks_sent++;
  endtask

  task automatic send_vector(input int kind);
    build_vector(kind);
    for (int b = 0; b < `SM_DEPTH; b++) begin
      send_block(vec_blocks[b]);
    end
  endtask

  task automatic wait_drain();
    @(posedge clk);
    in_valid <= 1'b0;
    while (expected.size() != 0) @(posedge clk);
  endtask

  always @(posedge clk) begin : drive_ready
    int rnd;
    rnd = $random(seed);
    out_ready <= ready_random ? rnd[0] : 1'b1;
  end

  always @(negedge clk) begin
    if (rst) begin
      prev_stall = 1'b0;
    end else begin
      if (prev_stall) begin
        if (out_valid !== 1'b1) begin
          other_count++;
          $display("out_valid dropped while out_ready was low");
        end
        check_block("out_data (stalled)", out_data, prev_data);
      end
      if (out_valid === 1'b1 && out_ready) begin
        if (expected.size() == 0) begin
          other_count++;
          $display("an output block arrived when none was expected");
        end else begin
          want = expected.pop_front();
          check_block("out_data", out_data, want);
        end
        blocks_seen++;
      end
      prev_stall = (out_valid === 1'b1) && !out_ready;
      prev_data = out_data;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d blocks still expected",
               cycle_count, expected.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    seed = 32'h7136_fd33;
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    gap_max = 0;
    ready_random = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle();

    send_vector(KIND_RANDOM); // single vector
    wait_drain();

    repeat (FULL_RATE_VECS) send_vector(KIND_RANDOM); // back to back
    wait_drain();

    gap_max = 3;
    ready_random = 1'b1;
    repeat (BP_VECS) send_vector(KIND_RANDOM);
    wait_drain();
    gap_max = 0;
    ready_random = 1'b0;

    send_vector(KIND_EQUAL);
    send_vector(KIND_MAX);
    send_vector(KIND_MIN);
    send_vector(KIND_ONE_MAX);
    wait_drain();
    repeat (2 * `SM_DIV_STAGES) @(posedge clk); // catch any stray output

    if (blocks_seen != blocks_sent) begin
      other_count++;
      $display("sent %0d blocks but received %0d", blocks_sent, blocks_seen);
    end
    $display("errors: %0d mismatches, %0d other failures, %0d blocks checked",
             mismatch_count, other_count, blocks_seen);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/fixed_softmax.sv
`timescale 1ns/1ps
`default_nettype none
`include "softmax_macros.svh"

module fixed_softmax (
  input logic clk,
  input logic rst,
  input logic [`SM_LANES*`SM_IN_W-1:0] in_data, // lane 0 in the low bits
  input logic in_valid,
  output logic in_ready,
  output logic [`SM_LANES*`SM_OUT_W-1:0] out_data,
  output logic out_valid,
  input logic out_ready
);
  import softmax_pkg::*;

  sum_t sum;
  logic sum_valid;
  logic sum_ready;

  softmax_block_if exp_to_fifo ();
  softmax_block_if exp_to_sum ();
  softmax_block_if fifo_to_div ();

  exp_stage u_exp_stage (
    .clk (clk),
    .rst (rst),
    .in_data (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .fifo_out (exp_to_fifo.src),
    .sum_out (exp_to_sum.src)
  );

  // exp blocks wait here for their vector total
  exp_fifo u_exp_fifo (
    .clk (clk),
    .rst (rst),
    .wr (exp_to_fifo.snk),
    .rd (fifo_to_div.src)
  );

  vector_sum u_vector_sum (
    .clk (clk),
    .rst (rst),
    .blk_in (exp_to_sum.snk),
    .sum (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready)
  );

  norm_divide u_norm_divide (
    .clk (clk),
    .rst (rst),
    .blk_in (fifo_to_div.snk),
    .sum (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready),
    .out_data (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

//--- logic/norm_divide.sv
`timescale 1ns/1ps
`default_nettype none
`include "softmax_macros.svh"

module norm_divide (
  input logic clk,
  input logic rst,
  softmax_block_if.snk blk_in,
  input softmax_pkg::sum_t sum,
  input logic sum_valid,
  output logic sum_ready,
  output softmax_pkg::out_block_t out_data,
  output logic out_valid,
  input logic out_ready
);
  import softmax_pkg::*;

  logic [`SM_EXP_W+`SM_EXP_FRAC-1:0] full_q [`SM_LANES];
  exp_block_t quot;
  exp_block_t q_pipe [`SM_DIV_STAGES];
  logic [`SM_DIV_STAGES-1:0] v_pipe;
  logic advance;
  logic fire;

  // add half an output lsb, drop the extra fraction bits, clip to max positive
  function automatic out_elem_t round_q(input exp_elem_t q);
    logic [`SM_EXP_W:0] half;
    logic [`SM_EXP_W:0] biased;
    logic [`SM_EXP_W:0] shifted;
    out_elem_t sat;
    half = '0;
    half[`SM_EXP_FRAC-`SM_OUT_FRAC-1] = 1'b1;
    sat = {1'b0, {(`SM_OUT_W-1){1'b1}}};
    biased = {1'b0, q} + half;
    shifted = biased >> (`SM_EXP_FRAC - `SM_OUT_FRAC);
    if (shifted > sat) return sat;
    return shifted[`SM_OUT_W-1:0];
  endfunction

  // whole pipe freezes while the output waits
  assign advance = !out_valid || out_ready;
  assign fire = blk_in.valid && sum_valid && advance;

  assign blk_in.ready = sum_valid && advance;
  assign sum_ready = blk_in.valid && advance;

  always_comb begin
    for (int l = 0; l < `SM_LANES; l++) begin
      full_q[l] = {blk_in.data[l], {`SM_EXP_FRAC{1'b0}}} / sum;
      quot[l] = full_q[l][`SM_EXP_W-1:0]; // truncate
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      v_pipe <= '0;
    end else if (advance) begin
      v_pipe <= {v_pipe[`SM_DIV_STAGES-2:0], fire};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      q_pipe[0] <= quot;
      for (int s = 1; s < `SM_DIV_STAGES; s++) begin
        q_pipe[s] <= q_pipe[s-1];
      end
    end
  end

  always_comb begin
    for (int l = 0; l < `SM_LANES; l++) begin
      out_data[l] = round_q(q_pipe[`SM_DIV_STAGES-1][l]);
    end
  end

  assign out_valid = v_pipe[`SM_DIV_STAGES-1];

  // the lower exp clamp upstream keeps every vector total nonzero
  a_sum_nonzero: assert property (@(posedge clk) disable iff (rst)
    fire |-> (sum != '0));

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- logic/vector_sum.sv
`timescale 1ns/1ps
`default_nettype none
`include "softmax_macros.svh"

module vector_sum (
  input logic clk,
  input logic rst,
  softmax_block_if.snk blk_in,
  output softmax_pkg::sum_t sum,
  output logic sum_valid,
  input logic sum_ready
);
  import softmax_pkg::*;

  sum_t tree_sum;
  sum_t acc;
  sum_t hold_sum;
  logic acc_full; // acc has a complete vector total
  blk_cnt_t blk_cnt;
  blk_cnt_t uses_left;
  hold_state_e hold_state;
  logic last_blk;
  logic hand_off;
  logic take;

  // lane reduction
  always_comb begin
    tree_sum = '0;
    for (int l = 0; l < `SM_LANES; l++) begin
      tree_sum = tree_sum + sum_t'(blk_in.data[l]);
    end
  end

  assign last_blk = (blk_cnt == blk_cnt_t'(`SM_DEPTH - 1));

  // total moves on when the hold register is free
  assign hand_off = acc_full && (hold_state == HOLD_EMPTY);

  // a finished total blocks new input until it has moved on
  assign blk_in.ready = !acc_full || hand_off;
  assign take = blk_in.valid && blk_in.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
      acc_full <= 1'b0;
      blk_cnt <= '0;
    end else if (take) begin
      acc <= (hand_off ? sum_t'(0) : acc) + tree_sum;
      acc_full <= last_blk;
      blk_cnt <= last_blk ? '0 : blk_cnt + 1'b1;
    end else if (hand_off) begin
      acc <= '0;
      acc_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hand_off) hold_sum <= acc;
  end

  // hold fsm, the sum is offered once per block of the vector
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_state <= HOLD_EMPTY;
      uses_left <= '0;
    end else begin
      case (hold_state)
        HOLD_EMPTY: begin
          if (hand_off) begin
            hold_state <= HOLD_REPEAT;
            uses_left <= blk_cnt_t'(`SM_DEPTH - 1);
          end
        end
        HOLD_REPEAT: begin
          if (sum_ready) begin
            if (uses_left == '0) begin
              hold_state <= HOLD_EMPTY; // last block used it
            end else begin
              uses_left <= uses_left - 1'b1;
            end
          end
        end
        default: hold_state <= HOLD_EMPTY;
      endcase
    end
  end

  assign sum = hold_sum;
  assign sum_valid = (hold_state == HOLD_REPEAT);

endmodule

`default_nettype wire

//--- logic/exp_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "softmax_macros.svh"

module exp_fifo (
  input logic clk,
  input logic rst,
  softmax_block_if.snk wr,
  softmax_block_if.src rd
);
  import softmax_pkg::*;

  exp_block_t mem [`SM_FIFO_BLOCKS];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  logic [$clog2(`SM_FIFO_BLOCKS):0] count;
  logic push;
  logic pop;

  assign wr.ready = (count != `SM_FIFO_BLOCKS);
  assign rd.valid = (count != 0);
  assign rd.data = mem[rd_ptr]; // head block

  assign push = wr.valid && wr.ready;
  assign pop = rd.valid && rd.ready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr.data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == fifo_ptr_t'(`SM_FIFO_BLOCKS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == fifo_ptr_t'(`SM_FIFO_BLOCKS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // occupancy never passes the buffer size and matches the pointer distance
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    (count <= `SM_FIFO_BLOCKS) && (fifo_ptr_t'(wr_ptr - rd_ptr) == fifo_ptr_t'(count)));

endmodule

`default_nettype wire

//--- logic/exp_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "softmax_macros.svh"

module exp_stage (
  input logic clk,
  input logic rst,
  input softmax_pkg::in_block_t in_data,
  input logic in_valid,
  output logic in_ready,
  softmax_block_if.src fifo_out,
  softmax_block_if.src sum_out
);
  import softmax_pkg::*;

  exp_elem_t exp_lut [2**`SM_IN_W];
  exp_block_t exp_vals;
  exp_block_t fork_data;
  logic fork_valid; // register holds a block
  logic fifo_taken;
  logic sum_taken;
  logic fifo_done;
  logic sum_done;
  logic both_done;
  logic load;

  // one rom entry per input code
  for (genvar c = 0; c < 2**`SM_IN_W; c++) begin : g_lut
    assign exp_lut[c] = exp_fixed(in_elem_t'(c));
  end

  always_comb begin
    for (int l = 0; l < `SM_LANES; l++) begin
      exp_vals[l] = exp_lut[in_data[l]];
    end
  end

  // each consumer done if taken earlier or taking now
  assign fifo_done = fifo_taken || (fifo_out.valid && fifo_out.ready);
  assign sum_done = sum_taken || (sum_out.valid && sum_out.ready);
  assign both_done = fifo_done && sum_done;

  assign in_ready = !fork_valid || both_done;
  assign load = in_valid && in_ready;

  assign fifo_out.data = fork_data;
  assign fifo_out.valid = fork_valid && !fifo_taken;
  assign sum_out.data = fork_data;
  assign sum_out.valid = fork_valid && !sum_taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      fork_valid <= 1'b0;
      fifo_taken <= 1'b0;
      sum_taken <= 1'b0;
    end else if (load) begin
      fork_valid <= 1'b1;
      fifo_taken <= 1'b0;
      sum_taken <= 1'b0;
    end else if (both_done) begin
      fork_valid <= 1'b0; // drained, nothing new
      fifo_taken <= 1'b0;
      sum_taken <= 1'b0;
    end else begin
      fifo_taken <= fifo_done;
      sum_taken <= sum_done;
    end
  end

  always_ff @(posedge clk) begin
    if (load) fork_data <= exp_vals;
  end

  // a copy not yet taken stays offered with the same block
  a_fifo_hold: assert property (@(posedge clk) disable iff (rst)
    fifo_out.valid && !fifo_out.ready |=> fifo_out.valid && $stable(fifo_out.data));

  a_sum_hold: assert property (@(posedge clk) disable iff (rst)
    sum_out.valid && !sum_out.ready |=> sum_out.valid && $stable(sum_out.data));

endmodule

`default_nettype wire

//--- logic/softmax_block_if.sv
`timescale 1ns/1ps
`default_nettype none

interface softmax_block_if;
  import softmax_pkg::*;

  exp_block_t data;
  logic valid;
  logic ready;

  modport src (
    output data,
    output valid,
    input ready
  );

  modport snk (
    input data,
    input valid,
    output ready
  );

endinterface

`default_nettype wire

//--- logic/softmax_pkg.sv
`default_nettype none
`include "softmax_macros.svh"

package softmax_pkg;

  typedef logic [`SM_IN_W-1:0] in_elem_t;
  typedef logic [`SM_EXP_W-1:0] exp_elem_t;
  typedef logic [`SM_SUM_W-1:0] sum_t;
  typedef logic [`SM_OUT_W-1:0] out_elem_t;

  typedef in_elem_t [`SM_LANES-1:0] in_block_t;
  typedef exp_elem_t [`SM_LANES-1:0] exp_block_t;
  typedef out_elem_t [`SM_LANES-1:0] out_block_t;

  typedef logic [$clog2(`SM_DEPTH)-1:0] blk_cnt_t;
  typedef logic [$clog2(`SM_FIFO_BLOCKS)-1:0] fifo_ptr_t;

  typedef enum logic {
    HOLD_EMPTY,
    HOLD_REPEAT
  } hold_state_e;

  // exp(x) in Q4.8, rounded, clamped to 1..4095 so a vector sum is never zero
  function automatic exp_elem_t exp_fixed(input in_elem_t code);
    real x;
    real scaled;
    int rounded;
    int max_code;
    max_code = (1 << `SM_EXP_W) - 1;
    x = real'($signed(code)) / real'(1 << `SM_IN_FRAC);
    scaled = $exp(x) * real'(1 << `SM_EXP_FRAC);
    rounded = $rtoi(scaled + 0.5);
    if (rounded < 1) rounded = 1;
    if (rounded > max_code) rounded = max_code;
    return exp_elem_t'(rounded);
  endfunction

endpackage

`default_nettype wire

//--- logic/softmax_macros.svh
`ifndef SOFTMAX_MACROS_SVH
`define SOFTMAX_MACROS_SVH

// input element, signed Q4.4
`define SM_IN_W 8
`define SM_IN_FRAC 4

// exponential value, unsigned Q4.8
`define SM_EXP_W 12
`define SM_EXP_FRAC 8

`define SM_OUT_W 8
`define SM_OUT_FRAC 4

`define SM_LANES 3 // elements per block
`define SM_DEPTH 4 // blocks per vector
`define SM_VEC_LEN (`SM_LANES * `SM_DEPTH)

`define SM_FIFO_BLOCKS (2 * `SM_DEPTH) // room for a second vector
`define SM_DIV_STAGES 4
`define SM_SUM_W (`SM_EXP_W + $clog2(`SM_VEC_LEN))

`endif
